//--- Bender.yml
package:
  name: pet_bus_core

sources:
  - hw/pet_bus_pkg.sv
  - hw/spi_command_receiver.sv
  - hw/bus_slot_timer.sv
  - hw/wb_target_router.sv
  - hw/ram_bridge.sv
  - hw/register_file.sv
  - hw/bus_pin_driver.sv
  - hw/pet_bus_top.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_pet_bus.sv

//--- hw/bus_pin_driver.sv
/*
 * Bus pin driver
 * Decodes the 6502 address into RAM strobes and chip selects in the
 * CPU phase and puts the RAM bridge on the shared pins otherwise
 */
`timescale 1ns/1ps
`default_nettype none

module bus_pin_driver (
    input  wire logic                                   cpu_be_i,
    input  wire logic                                   cpu_clock_i,
    input  wire logic [pet_bus_pkg::CPU_ADDR_WIDTH-1:0] cpu_addr_i,
    input  wire logic                                   cpu_we_i,
    input  wire pet_bus_pkg::ram_ctl_t                  ram_ctl_i,
    output logic [pet_bus_pkg::CPU_ADDR_WIDTH-1:0]      cpu_addr_o,
    output logic                                        cpu_addr_oe_o,
    output logic [pet_bus_pkg::DATA_WIDTH-1:0]          cpu_data_o,
    output logic                                        cpu_data_oe_o,
    output logic                                        ram_addr_a10_o,
    output logic                                        ram_addr_a11_o,
    output logic                                        ram_addr_a15_o,
    output logic                                        ram_addr_a16_o,
    output logic                                        ram_oe_o,
    output logic                                        ram_we_o,
    output logic                                        io_oe_o,
    output logic                                        pia1_cs_o,
    output logic                                        pia2_cs_o,
    output logic                                        via_cs_o
);
    import pet_bus_pkg::*;

    region_t cpu_region;
    logic    cpu_rd;
    logic    cpu_wr;

    assign cpu_region = decode_region({1'b0, cpu_addr_i});
    assign cpu_rd     = ~cpu_we_i & cpu_region.ram_en;
    assign cpu_wr     = cpu_we_i & cpu_clock_i & cpu_region.ram_en;  // Late write strobe

    assign io_oe_o   = cpu_be_i & cpu_region.io_en;
    assign pia1_cs_o = cpu_be_i & cpu_region.pia1_en;
    assign pia2_cs_o = cpu_be_i & cpu_region.pia2_en;
    assign via_cs_o  = cpu_be_i & cpu_region.via_en;

    assign ram_oe_o = cpu_be_i ? cpu_rd : ram_ctl_i.oe;
    assign ram_we_o = cpu_be_i ? cpu_wr : ram_ctl_i.we;

    // Bridge owns the shared address and data bus outside the CPU phase
    assign cpu_addr_o    = ram_ctl_i.addr[CPU_ADDR_WIDTH-1:0];
    assign cpu_addr_oe_o = ~cpu_be_i;
    assign cpu_data_o    = ram_ctl_i.data_out;
    assign cpu_data_oe_o = ~cpu_be_i & ram_ctl_i.data_oe;

    assign ram_addr_a10_o = cpu_be_i ? cpu_addr_i[10] : ram_ctl_i.addr[10];
    assign ram_addr_a11_o = cpu_be_i ? cpu_addr_i[11] : ram_ctl_i.addr[11];
    assign ram_addr_a15_o = cpu_be_i ? cpu_addr_i[15] : ram_ctl_i.addr[15];
    assign ram_addr_a16_o = cpu_be_i ? 1'b0 : ram_ctl_i.addr[16];

endmodule

`default_nettype wire

//--- hw/bus_slot_timer.sv
/*
 * Bus slot timer
 * Splits each CPU clock period into a Wishbone phase followed by a
 * CPU phase, and produces grant, bus-enable and CPU clock
 */
`timescale 1ns/1ps
`default_nettype none

module bus_slot_timer #(
    parameter int CYCLES_PER_PHASE = 4
) (
    input  wire logic sys_clock_i,
    input  wire logic rst_ni,
    output logic      wb_grant_o,
    output logic      cpu_be_o,
    output logic      cpu_clock_o
);
    localparam int PERIOD  = 2 * CYCLES_PER_PHASE;
    localparam int PHASE_W = $clog2(PERIOD);

    logic [PHASE_W-1:0] phase;
    logic [PHASE_W-1:0] phase_next;

    assign phase_next = (phase == PHASE_W'(PERIOD - 1)) ? '0 : phase + 1'b1;

    // Outputs registered from the next phase so they line up with it
    always_ff @(posedge sys_clock_i or negedge rst_ni) begin
        if (!rst_ni) begin
            phase       <= '0;
            wb_grant_o  <= 1'b0;
            cpu_be_o    <= 1'b0;
            cpu_clock_o <= 1'b0;
        end else begin
            phase       <= phase_next;
            wb_grant_o  <= (phase_next == '0);
            cpu_be_o    <= (phase_next >= PHASE_W'(CYCLES_PER_PHASE));
            cpu_clock_o <= (phase_next >= PHASE_W'(CYCLES_PER_PHASE + CYCLES_PER_PHASE / 2));
        end
    end

endmodule

`default_nettype wire

//--- hw/pet_bus_pkg.sv
/*
 * PET bus core shared definitions
 * Widths, address map, register indices and Wishbone structs
 */
`default_nettype none

package pet_bus_pkg;

    localparam int DATA_WIDTH     = 8;
    localparam int CPU_ADDR_WIDTH = 16;
    localparam int WB_ADDR_WIDTH  = 17;   // Bit 16 selects register space
    localparam int REG_ADDR_WIDTH = 2;

    localparam logic [7:0] IO_BASE = 8'hE8;  // CPU I/O page

    // One-hot device bits within addr[6:4] of the I/O page
    localparam logic [2:0] PIA1_SEL = 3'd1;
    localparam logic [2:0] PIA2_SEL = 3'd2;
    localparam logic [2:0] VIA_SEL  = 3'd4;

    localparam logic [REG_ADDR_WIDTH-1:0] REG_CTRL = 2'd0;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_ID   = 2'd1;
    localparam logic [DATA_WIDTH-1:0]     PET_ID   = 8'h50;

    typedef struct packed {
        logic ram_en;
        logic io_en;
        logic pia1_en;
        logic pia2_en;
        logic via_en;
        logic reg_en;
    } region_t;

    typedef struct packed {
        logic [WB_ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0]    data;
        logic                     we;
    } wb_req_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic                  ack;
        logic                  stall;
    } wb_rsp_t;

    // Bridge side of the RAM and shared CPU bus pins
    typedef struct packed {
        logic [WB_ADDR_WIDTH-1:0] addr;
        logic                     oe;
        logic                     we;
        logic [DATA_WIDTH-1:0]    data_out;
        logic                     data_oe;
    } ram_ctl_t;

    function automatic region_t decode_region(input logic [WB_ADDR_WIDTH-1:0] addr);
        region_t r;
        r = '0;
        if (addr[16]) begin
            r.reg_en = 1'b1;
        end else if (addr[15:8] == IO_BASE) begin
            r.io_en   = 1'b1;
            r.pia1_en = |(addr[6:4] & PIA1_SEL);
            r.pia2_en = |(addr[6:4] & PIA2_SEL);
            r.via_en  = |(addr[6:4] & VIA_SEL);
        end else begin
            r.ram_en = 1'b1;
        end
        return r;
    endfunction

endpackage

`default_nettype wire

//--- hw/pet_bus_top.sv
/*
 * PET bus core top level
 * SPI command port, slot timer, Wishbone targets and bus pin driver
 */
`timescale 1ns/1ps
`default_nettype none

module pet_bus_top #(
    parameter int CYCLES_PER_PHASE  = 4,
    parameter int RAM_ACCESS_CYCLES = 2
) (
    input  wire logic                                   sys_clock_i,
    input  wire logic                                   rst_ni,
    input  wire logic                                   spi_cs_ni,
    input  wire logic                                   spi_sck_i,
    input  wire logic                                   spi_sd_i,
    output logic                                        spi_sd_o,
    output logic                                        spi_stall_o,
    input  wire logic [pet_bus_pkg::CPU_ADDR_WIDTH-1:0] cpu_addr_i,
    input  wire logic [pet_bus_pkg::DATA_WIDTH-1:0]     cpu_data_i,
    input  wire logic                                   cpu_we_i,
    output logic                                        cpu_be_o,
    output logic                                        cpu_clock_o,
    output logic                                        cpu_ready_o,
    output logic                                        cpu_reset_o,
    output logic [pet_bus_pkg::CPU_ADDR_WIDTH-1:0]      cpu_addr_o,
    output logic                                        cpu_addr_oe_o,
    output logic [pet_bus_pkg::DATA_WIDTH-1:0]          cpu_data_o,
    output logic                                        cpu_data_oe_o,
    output logic                                        ram_addr_a10_o,
    output logic                                        ram_addr_a11_o,
    output logic                                        ram_addr_a15_o,
    output logic                                        ram_addr_a16_o,
    output logic                                        ram_oe_o,
    output logic                                        ram_we_o,
    output logic                                        io_oe_o,
    output logic                                        pia1_cs_o,
    output logic                                        pia2_cs_o,
    output logic                                        via_cs_o
);
    import pet_bus_pkg::*;

    wb_req_t  wb_req;
    wb_rsp_t  wb_rsp;
    wb_rsp_t  ram_rsp;
    wb_rsp_t  reg_rsp;
    ram_ctl_t ram_ctl;
    logic     wb_cyc;   // Held from request to ack
    logic     wb_stb;
    logic     wb_grant;
    logic     ram_stb;
    logic     reg_stb;

    spi_command_receiver u_spi (
        .sys_clock_i (sys_clock_i),
        .rst_ni      (rst_ni),
        .spi_cs_ni   (spi_cs_ni),
        .spi_sck_i   (spi_sck_i),
        .spi_sd_i    (spi_sd_i),
        .spi_sd_o    (spi_sd_o),
        .spi_stall_o (spi_stall_o),
        .wb_req_o    (wb_req),
        .wb_cyc_o    (wb_cyc),
        .wb_stb_o    (wb_stb),
        .wb_rsp_i    (wb_rsp)
    );

    bus_slot_timer #(
        .CYCLES_PER_PHASE (CYCLES_PER_PHASE)
    ) u_timer (
        .sys_clock_i (sys_clock_i),
        .rst_ni      (rst_ni),
        .wb_grant_o  (wb_grant),
        .cpu_be_o    (cpu_be_o),
        .cpu_clock_o (cpu_clock_o)
    );

    wb_target_router u_router (
        .wb_req_i   (wb_req),
        .wb_stb_i   (wb_stb & wb_cyc),
        .wb_grant_i (wb_grant),
        .ram_rsp_i  (ram_rsp),
        .reg_rsp_i  (reg_rsp),
        .ram_stb_o  (ram_stb),
        .reg_stb_o  (reg_stb),
        .wb_rsp_o   (wb_rsp)
    );

    ram_bridge #(
        .RAM_ACCESS_CYCLES (RAM_ACCESS_CYCLES)
    ) u_ram (
        .sys_clock_i (sys_clock_i),
        .rst_ni      (rst_ni),
        .wb_req_i    (wb_req),
        .wb_stb_i    (ram_stb),
        .ram_data_i  (cpu_data_i),
        .wb_rsp_o    (ram_rsp),
        .ram_ctl_o   (ram_ctl)
    );

    register_file u_regs (
        .sys_clock_i (sys_clock_i),
        .rst_ni      (rst_ni),
        .wb_req_i    (wb_req),
        .wb_stb_i    (reg_stb),
        .wb_rsp_o    (reg_rsp),
        .cpu_ready_o (cpu_ready_o),
        .cpu_reset_o (cpu_reset_o)
    );

    bus_pin_driver u_pins (
        .cpu_be_i       (cpu_be_o),
        .cpu_clock_i    (cpu_clock_o),
        .cpu_addr_i     (cpu_addr_i),
        .cpu_we_i       (cpu_we_i),
        .ram_ctl_i      (ram_ctl),
        .cpu_addr_o     (cpu_addr_o),
        .cpu_addr_oe_o  (cpu_addr_oe_o),
        .cpu_data_o     (cpu_data_o),
        .cpu_data_oe_o  (cpu_data_oe_o),
        .ram_addr_a10_o (ram_addr_a10_o),
        .ram_addr_a11_o (ram_addr_a11_o),
        .ram_addr_a15_o (ram_addr_a15_o),
        .ram_addr_a16_o (ram_addr_a16_o),
        .ram_oe_o       (ram_oe_o),
        .ram_we_o       (ram_we_o),
        .io_oe_o        (io_oe_o),
        .pia1_cs_o      (pia1_cs_o),
        .pia2_cs_o      (pia2_cs_o),
        .via_cs_o       (via_cs_o)
    );

endmodule

`default_nettype wire

//--- hw/ram_bridge.sv
/*
 * Wishbone to SRAM bridge
 * Runs one fixed-length read or write cycle per strobe and acks
 * one cycle after the access ends
 */
`timescale 1ns/1ps
`default_nettype none

module ram_bridge #(
    parameter int RAM_ACCESS_CYCLES = 2
) (
    input  wire logic                                sys_clock_i,
    input  wire logic                                rst_ni,
    input  wire pet_bus_pkg::wb_req_t                wb_req_i,
    input  wire logic                                wb_stb_i,
    input  wire logic [pet_bus_pkg::DATA_WIDTH-1:0]  ram_data_i,
    output pet_bus_pkg::wb_rsp_t                     wb_rsp_o,
    output pet_bus_pkg::ram_ctl_t                    ram_ctl_o
);
    import pet_bus_pkg::*;

    localparam int CNT_W = (RAM_ACCESS_CYCLES > 1) ? $clog2(RAM_ACCESS_CYCLES) : 1;

    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        ACK
    } state_t;

    state_t                   state;
    logic [CNT_W-1:0]         cnt;     // Access cycles left
    wb_req_t                  req_q;
    logic [DATA_WIDTH-1:0]    rdata_q;

    always_ff @(posedge sys_clock_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state <= IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                IDLE: if (wb_stb_i) begin
                    state <= ACCESS;
                    cnt   <= CNT_W'(RAM_ACCESS_CYCLES - 1);
                end
                ACCESS: begin
                    if (cnt == '0) state <= ACK;
                    else cnt <= cnt - 1'b1;
                end
                default: state <= IDLE;   // ACK lasts one cycle
            endcase
        end
    end

    always_ff @(posedge sys_clock_i) begin
        if (state == IDLE && wb_stb_i) begin
            req_q <= wb_req_i;
        end
        if (state == ACCESS && cnt == '0) begin
            rdata_q <= ram_data_i;  // Last access cycle
        end
    end

    assign wb_rsp_o.data  = rdata_q;
    assign wb_rsp_o.ack   = (state == ACK);
    assign wb_rsp_o.stall = (state != IDLE);

    assign ram_ctl_o.addr     = req_q.addr;
    assign ram_ctl_o.oe       = (state == ACCESS) & ~req_q.we;
    assign ram_ctl_o.we       = (state == ACCESS) & req_q.we;
    assign ram_ctl_o.data_out = req_q.data;
    assign ram_ctl_o.data_oe  = (state == ACCESS) & req_q.we;

endmodule

`default_nettype wire

//--- hw/register_file.sv
/*
 * Control register file
 * CPU ready and reset control plus a read-only ID register
 */
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  wire logic                 sys_clock_i,
    input  wire logic                 rst_ni,
    input  wire pet_bus_pkg::wb_req_t wb_req_i,
    input  wire logic                 wb_stb_i,
    output pet_bus_pkg::wb_rsp_t      wb_rsp_o,
    output logic                      cpu_ready_o,
    output logic                      cpu_reset_o
);
    import pet_bus_pkg::*;

    localparam logic [1:0] CTRL_RESET = 2'b10;  // CPU held in reset, not ready

    logic [REG_ADDR_WIDTH-1:0] index;
    logic [1:0]                ctrl_q;
    logic                      ack_q;
    logic [DATA_WIDTH-1:0]     rdata_q;

    assign index = wb_req_i.addr[REG_ADDR_WIDTH-1:0];

    always_ff @(posedge sys_clock_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ctrl_q <= CTRL_RESET;
            ack_q  <= 1'b0;
        end else begin
            ack_q <= wb_stb_i;
            if (wb_stb_i && wb_req_i.we && index == REG_CTRL) begin
                ctrl_q <= wb_req_i.data[1:0];
            end
        end
    end

    always_ff @(posedge sys_clock_i) begin
        if (wb_stb_i) begin
            case (index)
                REG_CTRL: rdata_q <= {{(DATA_WIDTH-2){1'b0}}, ctrl_q};
                REG_ID:   rdata_q <= PET_ID;
                default:  rdata_q <= '0;
            endcase
        end
    end

    assign wb_rsp_o.data  = rdata_q;
    assign wb_rsp_o.ack   = ack_q;
    assign wb_rsp_o.stall = 1'b0;  // Single-cycle target

    assign cpu_ready_o = ctrl_q[0];
    assign cpu_reset_o = ctrl_q[1];

endmodule

`default_nettype wire

//--- hw/spi_command_receiver.sv
/*
 * SPI command receiver
 * Mode-0 SPI target, oversampled on the system clock. A frame of
 * command, address high, address low and data bytes becomes one
 * pipelined Wishbone request. Read data is shifted back during the
 * fourth byte.
 */
`timescale 1ns/1ps
`default_nettype none

module spi_command_receiver (
    input  wire logic                 sys_clock_i,
    input  wire logic                 rst_ni,
    input  wire logic                 spi_cs_ni,
    input  wire logic                 spi_sck_i,
    input  wire logic                 spi_sd_i,
    output logic                      spi_sd_o,
    output logic                      spi_stall_o,
    output pet_bus_pkg::wb_req_t      wb_req_o,
    output logic                      wb_cyc_o,
    output logic                      wb_stb_o,
    input  wire pet_bus_pkg::wb_rsp_t wb_rsp_i
);
    import pet_bus_pkg::*;

    logic [2:0] sck_sync;   // Extra stage for edge detection
    logic [1:0] cs_sync;
    logic [1:0] sd_sync;
    logic       sck_rise;
    logic       sck_fall;
    logic       cs_active;

    logic [2:0]            bit_cnt;
    logic [2:0]            byte_cnt;  // Saturates at 4
    logic [6:0]            rx_shift;
    logic [DATA_WIDTH-1:0] byte_in;
    logic [DATA_WIDTH-1:0] tx_shift;
    logic                  cyc_q;
    logic                  sent_q;   // Strobe already accepted

    assign sck_rise  = sck_sync[1] & ~sck_sync[2];
    assign sck_fall  = ~sck_sync[1] & sck_sync[2];
    assign cs_active = ~cs_sync[1];
    assign byte_in   = {rx_shift, sd_sync[1]};

    always_ff @(posedge sys_clock_i or negedge rst_ni) begin
        if (!rst_ni) begin
            sck_sync <= '0;
            cs_sync  <= '1;
            sd_sync  <= '0;
        end else begin
            sck_sync <= {sck_sync[1:0], spi_sck_i};
            cs_sync  <= {cs_sync[0], spi_cs_ni};
            sd_sync  <= {sd_sync[0], spi_sd_i};
        end
    end

    // Frame position and incoming bytes
    always_ff @(posedge sys_clock_i or negedge rst_ni) begin
        if (!rst_ni) begin
            bit_cnt  <= '0;
            byte_cnt <= '0;
        end else if (!cs_active) begin
            bit_cnt  <= '0;
            byte_cnt <= '0;
        end else if (sck_rise) begin
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7 && byte_cnt != 3'd4) begin
                byte_cnt <= byte_cnt + 3'd1;
            end
        end
    end

    always_ff @(posedge sys_clock_i) begin
        if (cs_active && sck_rise) begin
            rx_shift <= byte_in[6:0];
            if (bit_cnt == 3'd7) begin
                case (byte_cnt)
                    3'd0: begin
                        wb_req_o.we       <= byte_in[7];
                        wb_req_o.addr[16] <= byte_in[0];
                    end
                    3'd1: wb_req_o.addr[15:8] <= byte_in;
                    3'd2: wb_req_o.addr[7:0]  <= byte_in;
                    3'd3: wb_req_o.data       <= byte_in;
                    default: ;
                endcase
            end
        end
    end

    // Wishbone cycle from frame completion to ack
    always_ff @(posedge sys_clock_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cyc_q  <= 1'b0;
            sent_q <= 1'b0;
        end else if (cyc_q) begin
            if (wb_rsp_i.ack) begin
                cyc_q  <= 1'b0;
                sent_q <= 1'b0;
            end else if (wb_stb_o) begin
                sent_q <= 1'b1;
            end
        end else if (cs_active && sck_rise && bit_cnt == 3'd7) begin
            // Read issues after address, write after data
            if ((byte_cnt == 3'd2 && !wb_req_o.we) || (byte_cnt == 3'd3 && wb_req_o.we)) begin
                cyc_q <= 1'b1;
            end
        end
    end

    assign wb_cyc_o    = cyc_q;
    assign wb_stb_o    = cyc_q & ~sent_q & ~wb_rsp_i.stall;
    assign spi_stall_o = cyc_q;

    // Outgoing data, MSB first, changes on falling SCK inside a byte
    always_ff @(posedge sys_clock_i or negedge rst_ni) begin
        if (!rst_ni) begin
            tx_shift <= '0;
        end else if (cyc_q && wb_rsp_i.ack && !wb_req_o.we) begin
            tx_shift <= wb_rsp_i.data;
        end else if (cs_active && sck_fall && bit_cnt != 3'd0) begin
            tx_shift <= {tx_shift[6:0], 1'b0};
        end
    end

    assign spi_sd_o = tx_shift[7];

endmodule

`default_nettype wire

//--- hw/wb_target_router.sv
/*
 * Wishbone target router
 * Sends a granted strobe to the register file or the RAM bridge and
 * merges their responses for the single master
 */
`timescale 1ns/1ps
`default_nettype none

module wb_target_router (
    input  wire pet_bus_pkg::wb_req_t wb_req_i,
    input  wire logic                 wb_stb_i,
    input  wire logic                 wb_grant_i,
    input  wire pet_bus_pkg::wb_rsp_t ram_rsp_i,
    input  wire pet_bus_pkg::wb_rsp_t reg_rsp_i,
    output logic                      ram_stb_o,
    output logic                      reg_stb_o,
    output pet_bus_pkg::wb_rsp_t      wb_rsp_o
);
    import pet_bus_pkg::*;

    region_t region;
    logic    stb_granted;

    assign region      = decode_region(wb_req_i.addr);
    assign stb_granted = wb_stb_i & wb_grant_i;

    // Everything outside register space goes through the RAM bridge
    assign reg_stb_o = stb_granted & region.reg_en;
    assign ram_stb_o = stb_granted & ~region.reg_en;

    always_comb begin
        wb_rsp_o.data  = region.reg_en ? reg_rsp_i.data : ram_rsp_i.data;
        wb_rsp_o.ack   = ram_rsp_i.ack | reg_rsp_i.ack;
        wb_rsp_o.stall = ~wb_grant_i | ram_rsp_i.stall | reg_rsp_i.stall;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+tb
hw/pet_bus_pkg.sv
hw/spi_command_receiver.sv
hw/bus_slot_timer.sv
hw/wb_target_router.sv
hw/ram_bridge.sv
hw/register_file.sv
hw/bus_pin_driver.sv
hw/pet_bus_top.sv
tb/tb_pet_bus.sv

//--- tb/spi_host_tasks.svh
/*
 * SPI host tasks for the PET bus testbench
 * Clocks mode-0 command frames into the DUT, MSB first, and waits
 * for spi_stall_o to drop before the next byte
 */
`ifndef SPI_HOST_TASKS_SVH
`define SPI_HOST_TASKS_SVH

task automatic wait_stall_clear();
    int waited;
    waited = 0;
    while (spi_stall === 1'b1 && waited < STALL_TIMEOUT) begin
        @(negedge sys_clock);
        waited++;
    end
    if (spi_stall !== 1'b0) begin
        $display("Timeout: spi_stall_o did not return low within %0d cycles at %0t",
                 STALL_TIMEOUT, $time);
        timeout_count++;
        report_and_finish();
    end
endtask

// One byte out on spi_sd_i and one byte back from spi_sd_o
task automatic exchange_byte(input logic [7:0] tx, output logic [7:0] rx);
    int i;
    rx = '0;
    for (i = 7; i >= 0; i--) begin
        spi_sdi <= tx[i];                   // Set up while SCK is low
        repeat (SCK_HALF) @(negedge sys_clock);
        rx[i] = spi_sdo;
        spi_sck <= 1'b1;
        repeat (SCK_HALF) @(negedge sys_clock);
        spi_sck <= 1'b0;
    end
endtask

// Command, address high, address low, then data or dummy byte
task automatic send_frame(input logic we, input logic [16:0] addr,
                          input logic [7:0] wdata, output logic [7:0] rdata);
    logic [7:0] rx_discard;
    spi_cs_n <= 1'b0;
    repeat (SCK_HALF) @(negedge sys_clock);
    exchange_byte({we, 6'b000000, addr[16]}, rx_discard);
    exchange_byte(addr[15:8], rx_discard);
    exchange_byte(addr[7:0], rx_discard);
    wait_stall_clear();                     // Read data is loaded once stall drops
    exchange_byte(wdata, rdata);
    wait_stall_clear();                     // Write acked
    spi_cs_n <= 1'b1;
    repeat (2 * SCK_HALF) @(negedge sys_clock);
endtask

`endif

//--- tb/tb_pet_bus.sv
/*
 * Testbench for the PET bus core
 * Sends SPI command frames while a random 6502 bus cycle runs in
 * every CPU phase. Models the shared SRAM and checks reset values,
 * RAM and register access, CPU-phase decode, bus ownership and
 * slot timing.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_pet_bus;

    localparam int CPP           = 4;   // System cycles per bus phase
    localparam int RAC           = 2;
    localparam int CLOCK_HALF    = 10;
    localparam int RESET_CYCLES  = 16;
    localparam int SCK_HALF      = 4;   // System cycles per SCK level
    localparam int STALL_TIMEOUT = 64;
    localparam int ROUND_TRIPS   = 4;

    localparam logic [16:0] CTRL_ADDR = 17'h1_0000;
    localparam logic [16:0] ID_ADDR   = 17'h1_0001;
    localparam logic [7:0]  ID_VALUE  = 8'h50;
    localparam logic [7:0]  IO_PAGE   = 8'hE8;

    logic        sys_clock;
    logic        rst_n;
    logic        spi_cs_n;
    logic        spi_sck;
    logic        spi_sdi;
    logic        spi_sdo;
    logic        spi_stall;
    logic [15:0] cpu_addr;
    logic [7:0]  cpu_data;      // SRAM read data towards the FPGA
    logic        cpu_we;
    logic [7:0]  cpu_wdata;     // Byte the 6502 drives when writing
    logic        cpu_be;
    logic        cpu_clock;
    logic        cpu_ready;
    logic        cpu_reset;
    logic [15:0] bus_addr;
    logic        bus_addr_oe;
    logic [7:0]  bus_data;
    logic        bus_data_oe;
    logic        ram_a10;
    logic        ram_a11;
    logic        ram_a15;
    logic        ram_a16;
    logic        ram_oe;
    logic        ram_we;
    logic        io_oe;
    logic        pia1_cs;
    logic        pia2_cs;
    logic        via_cs;

    int          seed;
    int          error_count;
    int          timeout_count;
    int          io_hits;
    int          rise_checks;
    int          period_cnt;
    int          be_cnt;
    logic        checks_on;
    logic        cpu_run;
    logic        cpu_clock_seen;
    logic        clk_prev;
    logic        rise_seen;
    logic [31:0] cpu_rand;
    logic [15:0] cpu_next;

    logic [7:0]  sram [0:131071];
    logic [15:0] shared_addr;
    logic [16:0] sram_addr;
    logic        exp_io;

    // SRAM sees the shared bus plus the four address lines the FPGA owns
    assign shared_addr = bus_addr_oe ? bus_addr : cpu_addr;
    assign sram_addr   = {ram_a16, ram_a15, shared_addr[14:12], ram_a11, ram_a10,
                          shared_addr[9:0]};
    assign exp_io      = (cpu_addr[15:8] == IO_PAGE);

    pet_bus_top #(
        .CYCLES_PER_PHASE  (CPP),
        .RAM_ACCESS_CYCLES (RAC)
    ) dut0 (
        .sys_clock_i    (sys_clock),
        .rst_ni         (rst_n),
        .spi_cs_ni      (spi_cs_n),
        .spi_sck_i      (spi_sck),
        .spi_sd_i       (spi_sdi),
        .spi_sd_o       (spi_sdo),
        .spi_stall_o    (spi_stall),
        .cpu_addr_i     (cpu_addr),
        .cpu_data_i     (cpu_data),
        .cpu_we_i       (cpu_we),
        .cpu_be_o       (cpu_be),
        .cpu_clock_o    (cpu_clock),
        .cpu_ready_o    (cpu_ready),
        .cpu_reset_o    (cpu_reset),
        .cpu_addr_o     (bus_addr),
        .cpu_addr_oe_o  (bus_addr_oe),
        .cpu_data_o     (bus_data),
        .cpu_data_oe_o  (bus_data_oe),
        .ram_addr_a10_o (ram_a10),
        .ram_addr_a11_o (ram_a11),
        .ram_addr_a15_o (ram_a15),
        .ram_addr_a16_o (ram_a16),
        .ram_oe_o       (ram_oe),
        .ram_we_o       (ram_we),
        .io_oe_o        (io_oe),
        .pia1_cs_o      (pia1_cs),
        .pia2_cs_o      (pia2_cs),
        .via_cs_o       (via_cs)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else begin
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h at %0t",
                     name, got, expected, $time);
            error_count++;
        end
    endtask

    task automatic report_and_finish();
        $display("Result: %0d check errors, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    endtask

    `include "spi_host_tasks.svh"

    initial begin
        sys_clock = 1'b0;
        forever #(CLOCK_HALF) sys_clock = ~sys_clock;
    end

    initial begin : sram_fill
        int a;
        for (a = 0; a < 131072; a++) begin
            sram[a] = 8'(a) ^ 8'(a >> 8) ^ 8'(a >> 16);
        end
        cpu_data = 8'hFF;
    end

    // SRAM model writes on ram_we_o and drives read data while ram_oe_o is high
    always @(posedge sys_clock) begin
        if (ram_we === 1'b1) begin
            sram[sram_addr] <= bus_data_oe ? bus_data : cpu_wdata;
        end
    end

    always @(negedge sys_clock) begin
        cpu_data <= (ram_oe === 1'b1) ? sram[sram_addr] : 8'hFF;
    end

    // New 6502 cycle after each falling CPU clock
    always @(negedge sys_clock) begin
        if (cpu_run && cpu_clock_seen && !cpu_clock) begin
            cpu_rand = $random(seed);
            cpu_next = cpu_rand[31:16];
            if (cpu_rand[1:0] == 2'b00) begin
                cpu_next[15:8] = IO_PAGE;       // Roughly one cycle in four
            end
            if (cpu_rand[2]) begin
                cpu_next[14] = 1'b1;            // Keeps CPU writes off the SPI test bytes
            end
            cpu_addr  <= cpu_next;
            cpu_we    <= cpu_rand[2];
            cpu_wdata <= cpu_rand[11:4];
        end
        cpu_clock_seen <= cpu_clock;
    end

    // CPU-phase decode and bus ownership
    always @(posedge sys_clock) begin
        if (checks_on) begin
            if (cpu_be) begin
                check_value("ram_addr_a10_o", ram_a10, cpu_addr[10]);
                check_value("ram_addr_a11_o", ram_a11, cpu_addr[11]);
                check_value("ram_addr_a15_o", ram_a15, cpu_addr[15]);
                check_value("ram_addr_a16_o", ram_a16, 1'b0);
                check_value("io_oe_o", io_oe, exp_io);
                check_value("pia1_cs_o", pia1_cs, exp_io & cpu_addr[4]);
                check_value("pia2_cs_o", pia2_cs, exp_io & cpu_addr[5]);
                check_value("via_cs_o", via_cs, exp_io & cpu_addr[6]);
                check_value("ram_oe_o", ram_oe, !exp_io && !cpu_we);
                check_value("ram_we_o", ram_we, !exp_io && cpu_we && cpu_clock);
                check_value("cpu_addr_oe_o", bus_addr_oe, 1'b0);
                check_value("cpu_data_oe_o", bus_data_oe, 1'b0);
                if (exp_io) begin
                    io_hits <= io_hits + 1;
                end
            end else begin
                check_value("io_oe_o", io_oe, 1'b0);
                check_value("pia1_cs_o", pia1_cs, 1'b0);
                check_value("pia2_cs_o", pia2_cs, 1'b0);
                check_value("via_cs_o", via_cs, 1'b0);
            end
        end
    end

    // Slot timing measured from one CPU clock rise to the next
    always @(posedge sys_clock) begin
        if (checks_on) begin
            if (cpu_clock && !clk_prev) begin
                if (rise_seen) begin
                    check_value("cpu_clock_o period", period_cnt, 2 * CPP);
                    check_value("cpu_be_o high cycles", be_cnt, CPP);
                    rise_checks <= rise_checks + 1;
                end
                rise_seen  <= 1'b1;
                period_cnt <= 1;
                be_cnt     <= cpu_be;
            end else begin
                period_cnt <= period_cnt + 1;
                be_cnt     <= be_cnt + cpu_be;
            end
            clk_prev <= cpu_clock;
        end
    end

    initial begin : main_sequence
        logic [15:0] trip_addr [ROUND_TRIPS];
        logic [7:0]  trip_data [ROUND_TRIPS];
        logic [7:0]  rx;
        int          n;

        seed           = 66713;
        error_count    = 0;
        timeout_count  = 0;
        io_hits        = 0;
        rise_checks    = 0;
        period_cnt     = 0;
        be_cnt         = 0;
        checks_on      = 1'b0;
        cpu_run        = 1'b0;
        cpu_clock_seen = 1'b0;
        clk_prev       = 1'b0;
        rise_seen      = 1'b0;
        rst_n          = 1'b0;
        spi_cs_n       = 1'b1;
        spi_sck        = 1'b0;
        spi_sdi        = 1'b0;
        cpu_addr       = '0;
        cpu_we         = 1'b0;
        cpu_wdata      = '0;
        for (n = 0; n < ROUND_TRIPS; n++) begin
            trip_addr[n] = 16'($random(seed)) & 16'hBFFF;  // Bit 14 clear avoids the I/O page
            trip_data[n] = 8'($random(seed));
        end

        repeat (RESET_CYCLES) @(negedge sys_clock);
        // Reset values just before release
        check_value("cpu_reset_o", cpu_reset, 1'b1);
        check_value("cpu_ready_o", cpu_ready, 1'b0);
        check_value("ram_oe_o", ram_oe, 1'b0);
        check_value("ram_we_o", ram_we, 1'b0);
        check_value("spi_stall_o", spi_stall, 1'b0);
        check_value("cpu_be_o", cpu_be, 1'b0);
        check_value("cpu_clock_o", cpu_clock, 1'b0);
        check_value("cpu_data_oe_o", bus_data_oe, 1'b0);
        check_value("pia1_cs_o", pia1_cs, 1'b0);
        check_value("pia2_cs_o", pia2_cs, 1'b0);
        check_value("via_cs_o", via_cs, 1'b0);
        rst_n     <= 1'b1;
        checks_on <= 1'b1;
        cpu_run   <= 1'b1;

        for (n = 0; n < ROUND_TRIPS; n++) begin
            send_frame(1'b1, {1'b0, trip_addr[n]}, trip_data[n], rx);
            send_frame(1'b0, {1'b0, trip_addr[n]}, 8'h00, rx);
            check_value("spi_sd_o RAM read", rx, trip_data[n]);
            check_value("SRAM model byte", sram[{1'b0, trip_addr[n]}], trip_data[n]);
        end

        send_frame(1'b1, CTRL_ADDR, 8'h01, rx);
        check_value("cpu_ready_o", cpu_ready, 1'b1);
        check_value("cpu_reset_o", cpu_reset, 1'b0);
        send_frame(1'b0, CTRL_ADDR, 8'h00, rx);
        check_value("spi_sd_o control register", rx, 8'h01);
        send_frame(1'b0, ID_ADDR, 8'h00, rx);
        check_value("spi_sd_o ID register", rx, ID_VALUE);

        repeat (8 * CPP) @(negedge sys_clock);
        if (rise_checks == 0 || io_hits == 0) begin
            $display("Slot timing or I/O decode checks were never reached");
            error_count++;
        end
        report_and_finish();
    end

endmodule

`default_nettype wire
